//--- verilog/tracker_pkg.sv
package tracker_pkg;

    // ####################################################################
    // Field widths
    // ####################################################################

    localparam int TAG_WIDTH     = 4;
    localparam int ROUTE_WIDTH   = 4;
    localparam int PAYLOAD_WIDTH = 8;

    typedef logic [TAG_WIDTH-1:0]     tag_t;
    typedef logic [ROUTE_WIDTH-1:0]   route_t;
    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

    // ####################################################################
    // Controller FSM
    // ####################################################################

    typedef enum logic [2:0] {
        IDLE,
        ISSUE_ACK,
        OUT_REQ,
        OUT_RELEASE,
        RSP_ACK
    } ctrl_state_t;

endpackage

//--- verilog/tag_list.sv
`timescale 1ns/100ps

module tag_list #(
    parameter int DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic                rd_en,
    input  tracker_pkg::tag_t   wr_tag,
    input  tracker_pkg::route_t wr_route,
    input  tracker_pkg::tag_t   search_tag,
    output logic                search_hit,
    output tracker_pkg::route_t rd_route,
    output logic                full,
    output logic                empty
);

    localparam int SEL_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0]     valid;
    tracker_pkg::tag_t    tag_mem   [DEPTH];
    tracker_pkg::route_t  route_mem [DEPTH];

    logic [DEPTH-1:0]     match;
    logic [DEPTH-1:0]     set_mask;
    logic [DEPTH-1:0]     clr_mask;
    logic [SEL_WIDTH-1:0] wr_sel;
    logic [SEL_WIDTH-1:0] rd_sel;

    // ####################################################################
    // Per-slot compare and update masks
    // ####################################################################

    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        assign match[i]    = valid[i] && (tag_mem[i] == search_tag);
        assign set_mask[i] = wr_en && !valid[i] && (wr_sel == SEL_WIDTH'(i));
        assign clr_mask[i] = rd_en && match[i] && (rd_sel == SEL_WIDTH'(i));
    end

    // Lowest free slot and lowest matching slot
    always_comb begin
        wr_sel = '0;
        rd_sel = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                wr_sel = SEL_WIDTH'(i);
            end
            if (match[i]) begin
                rd_sel = SEL_WIDTH'(i);
            end
        end
    end

    assign search_hit = |match;
    assign rd_route   = route_mem[rd_sel];
    assign full       = &valid;
    assign empty      = ~|valid;

    // Write and removal never touch the same slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~clr_mask) | set_mask;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (set_mask[i]) begin
                tag_mem[i]   <= wr_tag;
                route_mem[i] <= wr_route;
            end
        end
    end

    // ####################################################################
    // Checks
    // ####################################################################

    // Controller must have rejected the issue
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !full
    ) else $error("tag_list: write while full");

    // Duplicate filtering keeps tags unique
    a_one_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(match)
    ) else $error("tag_list: several slots match tag %0h", search_tag);

endmodule

//--- verilog/tracker_ctrl.sv
`timescale 1ns/100ps

module tracker_ctrl (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              issue_req,
    input  tracker_pkg::tag_t issue_tag,
    output logic              issue_ack,
    output logic              issue_ok,

    input  logic              rsp_req,
    input  tracker_pkg::tag_t rsp_tag,
    output logic              rsp_ack,
    output logic              rsp_hit,

    output logic              out_req,
    input  logic              out_ack,

    output tracker_pkg::tag_t search_tag,
    input  logic              search_hit,
    input  logic              full,
    output logic              wr_en,
    output logic              rd_en,
    output logic              load,

    output logic              dup_event,
    output logic              full_event,
    output logic              orphan_event
);

    tracker_pkg::ctrl_state_t state;
    tracker_pkg::ctrl_state_t state_nxt;

    logic issue_ok_q;
    logic rsp_hit_q;

    // Responses win arbitration, so the key follows rsp_req
    assign search_tag = rsp_req ? rsp_tag : issue_tag;

    // ####################################################################
    // Next state and list strobes
    // ####################################################################

    always_comb begin
        state_nxt    = state;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        load         = 1'b0;
        dup_event    = 1'b0;
        full_event   = 1'b0;
        orphan_event = 1'b0;

        case (state)
            tracker_pkg::IDLE: begin
                if (rsp_req) begin
                    if (search_hit) begin
                        rd_en     = 1'b1;
                        load      = 1'b1;
                        state_nxt = tracker_pkg::OUT_REQ;
                    end else begin
                        orphan_event = 1'b1;
                        state_nxt    = tracker_pkg::RSP_ACK;
                    end
                end else if (issue_req) begin
                    if (search_hit) begin
                        dup_event = 1'b1;
                    end else if (full) begin
                        full_event = 1'b1;
                    end else begin
                        wr_en = 1'b1;
                    end
                    state_nxt = tracker_pkg::ISSUE_ACK;
                end
            end

            tracker_pkg::ISSUE_ACK: begin
                if (!issue_req) begin
                    state_nxt = tracker_pkg::IDLE;
                end
            end

            tracker_pkg::OUT_REQ: begin
                if (out_ack) begin
                    state_nxt = tracker_pkg::OUT_RELEASE;
                end
            end

            // Consumer still holding ack
            tracker_pkg::OUT_RELEASE: begin
                if (!out_ack) begin
                    state_nxt = tracker_pkg::RSP_ACK;
                end
            end

            tracker_pkg::RSP_ACK: begin
                if (!rsp_req) begin
                    state_nxt = tracker_pkg::IDLE;
                end
            end

            default: begin
                state_nxt = tracker_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= tracker_pkg::IDLE;
            issue_ok_q <= 1'b0;
            rsp_hit_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == tracker_pkg::IDLE && rsp_req) begin
                rsp_hit_q <= search_hit;
            end else if (state == tracker_pkg::IDLE && issue_req) begin
                issue_ok_q <= !search_hit && !full;
            end
        end
    end

    assign issue_ack = (state == tracker_pkg::ISSUE_ACK);
    assign rsp_ack   = (state == tracker_pkg::RSP_ACK);
    assign out_req   = (state == tracker_pkg::OUT_REQ);
    assign issue_ok  = issue_ok_q;
    assign rsp_hit   = rsp_hit_q;

    // ####################################################################
    // Checks
    // ####################################################################

    a_one_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(issue_ack && rsp_ack)
    ) else $error("tracker_ctrl: issue_ack and rsp_ack both high");

    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req
    ) else $error("tracker_ctrl: out_req dropped before out_ack");

endmodule

//--- verilog/resp_merge.sv
`timescale 1ns/100ps

module resp_merge (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  tracker_pkg::route_t   rd_route,
    input  tracker_pkg::tag_t     rsp_tag,
    input  tracker_pkg::payload_t rsp_payload,
    output tracker_pkg::tag_t     out_tag,
    output tracker_pkg::route_t   out_route,
    output tracker_pkg::payload_t out_payload
);

    tracker_pkg::tag_t     tag_q;
    tracker_pkg::route_t   route_q;
    tracker_pkg::payload_t payload_q;

    // ####################################################################
    // Output holding register
    // ####################################################################

    // Captured on the removal edge, so the freed slot may be reused
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q     <= '0;
            route_q   <= '0;
            payload_q <= '0;
        end else if (load) begin
            tag_q     <= rsp_tag;
            route_q   <= rd_route;
            payload_q <= rsp_payload;
        end
    end

    assign out_tag     = tag_q;
    assign out_route   = route_q;
    assign out_payload = payload_q;

endmodule

//--- verilog/err_counter.sv
`timescale 1ns/100ps

module err_counter #(
    parameter int CNT_WIDTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dup_event,
    input  logic                 full_event,
    input  logic                 orphan_event,
    output logic [CNT_WIDTH-1:0] dup_count,
    output logic [CNT_WIDTH-1:0] full_count,
    output logic [CNT_WIDTH-1:0] orphan_count
);

    logic [2:0]                 events;
    logic [2:0][CNT_WIDTH-1:0]  cnt;

    assign events = {orphan_event, full_event, dup_event};

    // Stop at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (events[i] && !(&cnt[i])) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign dup_count    = cnt[0];
    assign full_count   = cnt[1];
    assign orphan_count = cnt[2];

endmodule

//--- verilog/tracker_top.sv
`timescale 1ns/100ps

module tracker_top #(
    parameter int DEPTH     = 8,
    parameter int CNT_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  issue_req,
    input  tracker_pkg::tag_t     issue_tag,
    input  tracker_pkg::route_t   issue_route,
    output logic                  issue_ack,
    output logic                  issue_ok,

    input  logic                  rsp_req,
    input  tracker_pkg::tag_t     rsp_tag,
    input  tracker_pkg::payload_t rsp_payload,
    output logic                  rsp_ack,
    output logic                  rsp_hit,

    output logic                  out_req,
    output tracker_pkg::tag_t     out_tag,
    output tracker_pkg::route_t   out_route,
    output tracker_pkg::payload_t out_payload,
    input  logic                  out_ack,

    output logic                  full,
    output logic                  empty,
    output logic [CNT_WIDTH-1:0]  dup_count,
    output logic [CNT_WIDTH-1:0]  full_count,
    output logic [CNT_WIDTH-1:0]  orphan_count
);

    tracker_pkg::tag_t   search_tag;
    tracker_pkg::route_t rd_route;
    logic                search_hit;
    logic                wr_en;
    logic                rd_en;
    logic                load;
    logic                dup_event;
    logic                full_event;
    logic                orphan_event;

    tracker_ctrl u_tracker_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_req    (issue_req),
        .issue_tag    (issue_tag),
        .issue_ack    (issue_ack),
        .issue_ok     (issue_ok),
        .rsp_req      (rsp_req),
        .rsp_tag      (rsp_tag),
        .rsp_ack      (rsp_ack),
        .rsp_hit      (rsp_hit),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .search_tag   (search_tag),
        .search_hit   (search_hit),
        .full         (full),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .load         (load),
        .dup_event    (dup_event),
        .full_event   (full_event),
        .orphan_event (orphan_event)
    );

    tag_list #(
        .DEPTH (DEPTH)
    ) u_tag_list (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .wr_tag     (issue_tag),
        .wr_route   (issue_route),
        .search_tag (search_tag),
        .search_hit (search_hit),
        .rd_route   (rd_route),
        .full       (full),
        .empty      (empty)
    );

    resp_merge u_resp_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .rd_route    (rd_route),
        .rsp_tag     (rsp_tag),
        .rsp_payload (rsp_payload),
        .out_tag     (out_tag),
        .out_route   (out_route),
        .out_payload (out_payload)
    );

    err_counter #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_err_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .dup_event    (dup_event),
        .full_event   (full_event),
        .orphan_event (orphan_event),
        .dup_count    (dup_count),
        .full_count   (full_count),
        .orphan_count (orphan_count)
    );

endmodule

//--- sim/tb_tracker_top.sv
`timescale 1ns/100ps

module tb_tracker_top;

    localparam int DEPTH      = 8;
    localparam int CNT_WIDTH  = 8;
    localparam int NUM_TAGS   = 1 << tracker_pkg::TAG_WIDTH;
    localparam int NUM_OPS    = 39;
    localparam int MAX_CYCLES = 40 * NUM_OPS;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_req;
    logic                  issue_ack;
    logic                  issue_ok;
    tracker_pkg::tag_t     issue_tag;
    tracker_pkg::route_t   issue_route;
    logic                  rsp_req;
    logic                  rsp_ack;
    logic                  rsp_hit;
    tracker_pkg::tag_t     rsp_tag;
    tracker_pkg::payload_t rsp_payload;
    logic                  out_req;
    logic                  out_ack;
    tracker_pkg::tag_t     out_tag;
    tracker_pkg::route_t   out_route;
    tracker_pkg::payload_t out_payload;
    logic                  full;
    logic                  empty;
    logic [CNT_WIDTH-1:0]  dup_count;
    logic [CNT_WIDTH-1:0]  full_count;
    logic [CNT_WIDTH-1:0]  orphan_count;

    // Reference table of outstanding tags
    logic                  ref_valid [NUM_TAGS];
    tracker_pkg::route_t   ref_route [NUM_TAGS];
    int                    ref_cnt;
    tracker_pkg::tag_t     perm [NUM_TAGS];

    // Expected results of the handshake in flight
    logic                  exp_issue_ok;
    logic                  exp_rsp_hit;
    logic                  exp_full_flag;
    logic                  exp_empty_flag;
    tracker_pkg::tag_t     exp_tag;
    tracker_pkg::route_t   exp_route;
    tracker_pkg::payload_t exp_payload;
    logic [CNT_WIDTH-1:0]  exp_dup;
    logic [CNT_WIDTH-1:0]  exp_fullc;
    logic [CNT_WIDTH-1:0]  exp_orphan;
    int                    errors;
    int                    checks;
    int                    cycle_count;

    tracker_top #(.DEPTH(DEPTH), .CNT_WIDTH(CNT_WIDTH)) u_tracker_top (.*);

    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic protocol_error(input string what);
        $display("Handshake order broken at %0t: %s", $time, what);
        errors++;
    endtask

    // Fisher-Yates over the first n entries of perm
    task automatic shuffle_tags(input int n);
        int j;
        tracker_pkg::tag_t t;
        for (int i = n - 1; i > 0; i--) begin
            j = $urandom_range(i, 0);
            t = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
    endtask

    task automatic issue_txn(input tracker_pkg::tag_t tag, input tracker_pkg::route_t route);
        if (ref_valid[tag]) begin
            exp_issue_ok = 1'b0;
            exp_dup = exp_dup + CNT_WIDTH'(1);
        end else if (ref_cnt == DEPTH) begin
            exp_issue_ok = 1'b0;
            exp_fullc = exp_fullc + CNT_WIDTH'(1);
        end else begin
            exp_issue_ok = 1'b1;
            ref_valid[tag] = 1'b1;
            ref_route[tag] = route;
            ref_cnt++;
        end
        exp_full_flag = (ref_cnt == DEPTH);
        exp_empty_flag = (ref_cnt == 0);
        issue_tag = tag;
        issue_route = route;
        issue_req = 1'b1;
        while (!issue_ack) begin
            @(negedge clk);
        end
        issue_req = 1'b0;
        while (issue_ack) begin
            @(negedge clk);
        end
        checks++;
    endtask

    // Consumer answers out_req after a random number of cycles
    task automatic answer_txn(input tracker_pkg::tag_t tag, input tracker_pkg::payload_t payload,
                              input int max_delay);
        int delay;
        exp_rsp_hit = ref_valid[tag];
        if (ref_valid[tag]) begin
            exp_tag = tag;
            exp_route = ref_route[tag];
            exp_payload = payload;
            ref_valid[tag] = 1'b0;
            ref_cnt--;
        end else begin
            exp_orphan = exp_orphan + CNT_WIDTH'(1);
        end
        exp_full_flag = (ref_cnt == DEPTH);
        exp_empty_flag = (ref_cnt == 0);
        rsp_tag = tag;
        rsp_payload = payload;
        rsp_req = 1'b1;
        while (!rsp_ack) begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                delay = $urandom_range(max_delay, 0);
                repeat (delay) @(negedge clk);
                out_ack = 1'b1;
            end else if (!out_req && out_ack) begin
                out_ack = 1'b0;
            end
        end
        rsp_req = 1'b0;
        while (rsp_ack) begin
            @(negedge clk);
        end
        checks++;
    endtask

    // ####################################################################
    // Checks
    // ####################################################################

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> {issue_ack, rsp_ack, out_req} == 3'b000)
        else report_mismatch("{issue_ack,rsp_ack,out_req}", 0,
                             int'($sampled({issue_ack, rsp_ack, out_req})));
    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) || $rose(issue_ack) || $rose(rsp_ack)
            |-> {full, empty} == {exp_full_flag, exp_empty_flag})
        else report_mismatch("{full,empty}", int'({exp_full_flag, exp_empty_flag}),
                             int'($sampled({full, empty})));
    a_counts: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) || $rose(issue_ack) || $rose(rsp_ack)
            |-> {dup_count, full_count, orphan_count} == {exp_dup, exp_fullc, exp_orphan})
        else report_mismatch("{dup_count,full_count,orphan_count}",
                             int'({exp_dup, exp_fullc, exp_orphan}),
                             int'($sampled({dup_count, full_count, orphan_count})));
    a_issue_ok: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(issue_ack) |-> issue_ok == exp_issue_ok)
        else report_mismatch("issue_ok", int'(exp_issue_ok), int'($sampled(issue_ok)));
    a_rsp_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_ack) |-> rsp_hit == exp_rsp_hit)
        else report_mismatch("rsp_hit", int'(exp_rsp_hit), int'($sampled(rsp_hit)));
    a_out_fields: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> {out_tag, out_route, out_payload} == {exp_tag, exp_route, exp_payload})
        else report_mismatch("{out_tag,out_route,out_payload}",
                             int'({exp_tag, exp_route, exp_payload}),
                             int'($sampled({out_tag, out_route, out_payload})));
    a_miss_no_out: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_req && !exp_rsp_hit |-> !out_req)
        else protocol_error("out_req raised for a response that missed");

    // Four-phase order on each port
    a_issue_order: assert property (@(posedge clk) disable iff (!rst_n)
        (!$rose(issue_ack) || $past(issue_req)) && (!$fell(issue_ack) || !$past(issue_req)))
        else protocol_error("issue_ack moved out of four-phase order");
    a_rsp_order: assert property (@(posedge clk) disable iff (!rst_n)
        (!$rose(rsp_ack) || $past(rsp_req)) && (!$fell(rsp_ack) || !$past(rsp_req)))
        else protocol_error("rsp_ack moved out of four-phase order");
    a_out_order: assert property (@(posedge clk) disable iff (!rst_n)
        (!$rose(out_req) || !$past(out_ack)) && (!$fell(out_req) || $past(out_ack)))
        else protocol_error("out_req moved out of four-phase order");

    // ####################################################################
    // Stimulus
    // ####################################################################

    initial begin : stimulus
        tracker_pkg::tag_t   tag;
        tracker_pkg::route_t route;
        void'($urandom(32'hd3d5));
        clk = 1'b0;
        rst_n = 1'b0;
        issue_req = 1'b0;
        issue_tag = '0;
        issue_route = '0;
        rsp_req = 1'b0;
        rsp_tag = '0;
        rsp_payload = '0;
        out_ack = 1'b0;
        errors = 0;
        checks = 0;
        ref_cnt = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            ref_valid[i] = 1'b0;
            ref_route[i] = '0;
            perm[i] = tracker_pkg::tag_t'(i);
        end
        exp_issue_ok = 1'b0;
        exp_rsp_hit = 1'b0;
        exp_full_flag = 1'b0;
        exp_empty_flag = 1'b1;
        exp_tag = '0;
        exp_route = '0;
        exp_payload = '0;
        exp_dup = '0;
        exp_fullc = '0;
        exp_orphan = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;

        // Single issue and response
        tag = tracker_pkg::tag_t'($urandom);
        issue_txn(tag, tracker_pkg::route_t'($urandom));
        answer_txn(tag, tracker_pkg::payload_t'($urandom), 2);

        // Eight tags answered out of order
        shuffle_tags(NUM_TAGS);
        for (int i = 0; i < DEPTH; i++) begin
            issue_txn(perm[i], tracker_pkg::route_t'($urandom));
        end
        shuffle_tags(DEPTH);
        for (int i = 0; i < DEPTH; i++) begin
            answer_txn(perm[i], tracker_pkg::payload_t'($urandom), 6);
        end

        // Duplicate issue keeps the first route
        tag = tracker_pkg::tag_t'($urandom);
        route = tracker_pkg::route_t'($urandom);
        issue_txn(tag, route);
        issue_txn(tag, ~route);
        answer_txn(tag, tracker_pkg::payload_t'($urandom), 2);

        // Fill, overflow, one response, drain
        shuffle_tags(NUM_TAGS);
        for (int i = 0; i <= DEPTH; i++) begin
            issue_txn(perm[i], tracker_pkg::route_t'($urandom));
        end
        answer_txn(perm[$urandom_range(DEPTH - 1, 0)], tracker_pkg::payload_t'($urandom), 2);
        for (int i = 0; i < DEPTH; i++) begin
            if (ref_valid[perm[i]]) begin
                answer_txn(perm[i], tracker_pkg::payload_t'($urandom), 2);
            end
        end

        // Orphan response on an empty list
        answer_txn(tracker_pkg::tag_t'($urandom), tracker_pkg::payload_t'($urandom), 0);

        repeat (3) @(negedge clk);
        $display("Checked handshakes: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sources.f
verilog/tracker_pkg.sv
verilog/tag_list.sv
verilog/tracker_ctrl.sv
verilog/resp_merge.sv
verilog/err_counter.sv
verilog/tracker_top.sv
sim/tb_tracker_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_tracker_top -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tracker_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F ">>> FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
exit 0
